// ==== hdl/l2_wr_pkg.sv ====
`default_nettype none

package l2_wr_pkg;

    // line geometry
    localparam int OFFSET_WIDTH = 2;
    localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;
    localparam int LINE_BITS    = LINE_WORDS * 32;

    // lines held by the write buffer
    localparam int WRT_DEPTH = 2;

    // axi size codes
    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

    // write path state, shared by controller and arbiter
    typedef enum logic [4:0] {
        IDLE   = 5'd0,
        DMA_AW = 5'd1,
        DMA_W  = 5'd2,
        DMA_R  = 5'd3,
        WRT_W  = 5'd4
    } wr_state_e;

endpackage

`default_nettype wire

// ==== hdl/l2_wr_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_wr_ctrl (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   l2_req,
    input  wire                   l2_uncached,
    input  wire                   wrt_empty,
    input  wire                   aw_ready,
    input  wire                   w_ready,
    input  wire                   b_valid,
    output l2_wr_pkg::wr_state_e  state
);

    import l2_wr_pkg::*;

    wr_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // buffered lines drain before any direct store
                if (!wrt_empty) begin
                    state_nxt = WRT_W;
                end else if (l2_req && l2_uncached) begin
                    state_nxt = DMA_AW;
                end
            end
            WRT_W: begin
                if (wrt_empty) begin
                    state_nxt = IDLE;
                end
            end
            DMA_AW: begin
                if (aw_ready) begin
                    state_nxt = DMA_W;
                end
            end
            DMA_W: begin
                if (w_ready) begin
                    state_nxt = DMA_R;
                end
            end
            DMA_R: begin
                // response also acknowledges the l2 request
                if (b_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // buffer stays empty for the whole direct store
    assert property (@(posedge clk) disable iff (!arst_n)
        state inside {DMA_AW, DMA_W, DMA_R} |-> wrt_empty);

    // response phase ends only with a response
    assert property (@(posedge clk) disable iff (!arst_n)
        (state == DMA_R) ##1 (state != DMA_R) |-> $past(b_valid));

endmodule

`default_nettype wire

// ==== hdl/write_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module write_buffer (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              wrt_req,
    input  wire  [31:0]                      wrt_addr,
    input  wire  [l2_wr_pkg::LINE_BITS-1:0]  wrt_line,
    output logic                             wrt_addr_ok,
    output logic                             wrt_aw_valid,
    output logic [31:0]                      wrt_aw_addr,
    input  wire                              aw_ready,
    output logic                             wrt_w_valid,
    output logic [31:0]                      wrt_w_data,
    output logic                             wrt_w_last,
    input  wire                              w_ready,
    output logic                             wrt_b_ready,
    input  wire                              b_valid,
    output logic                             wrt_empty
);

    import l2_wr_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_AW,
        SEQ_W,
        SEQ_B
    } seq_e;

    logic [31:0]          addr_q [WRT_DEPTH];
    logic [LINE_BITS-1:0] line_q [WRT_DEPTH];

    logic [$clog2(WRT_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(WRT_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(WRT_DEPTH+1)-1:0] count;
    logic [OFFSET_WIDTH-1:0]        beat;
    seq_e                           seq;
    seq_e                           seq_nxt;

    logic accept;
    logic aw_done;
    logic w_done;
    logic free;

    assign wrt_addr_ok = (count != WRT_DEPTH);
    assign accept      = wrt_req && wrt_addr_ok;
    assign aw_done     = wrt_aw_valid && aw_ready;
    assign w_done      = wrt_w_valid && w_ready;
    assign free        = wrt_b_ready && b_valid;

    // line storage, written at the tail
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q[wr_ptr] <= wrt_addr;
            line_q[wr_ptr] <= wrt_line;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // head entry is released by its write response
            if (free) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({accept, free})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // burst sequencer for the head entry
    always_comb begin
        seq_nxt = seq;
        case (seq)
            SEQ_IDLE: begin
                // start right after the first entry lands
                if (count != 0 || accept) begin
                    seq_nxt = SEQ_AW;
                end
            end
            SEQ_AW: begin
                if (aw_done) begin
                    seq_nxt = SEQ_W;
                end
            end
            SEQ_W: begin
                if (w_done && wrt_w_last) begin
                    seq_nxt = SEQ_B;
                end
            end
            SEQ_B: begin
                if (free) begin
                    seq_nxt = SEQ_IDLE;
                end
            end
            default: begin
                seq_nxt = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seq  <= SEQ_IDLE;
            beat <= '0;
        end else begin
            seq <= seq_nxt;
            // wraps back to zero after the last beat
            if (w_done) begin
                beat <= beat + 1'b1;
            end
        end
    end

    assign wrt_aw_valid = (seq == SEQ_AW);
    assign wrt_aw_addr  = {addr_q[rd_ptr][31:OFFSET_WIDTH+2], {(OFFSET_WIDTH + 2){1'b0}}};
    assign wrt_w_valid  = (seq == SEQ_W);
    assign wrt_w_data   = line_q[rd_ptr][beat*32 +: 32];
    assign wrt_w_last   = wrt_w_valid && (beat == OFFSET_WIDTH'(LINE_WORDS - 1));
    assign wrt_b_ready  = (seq == SEQ_B);
    assign wrt_empty    = (count == 0) && (seq == SEQ_IDLE);

    // a write never lands on a line still waiting for its response
    assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> (count == 0) || (wr_ptr != rd_ptr));

    // last beat closes the burst on the fourth word and hands over to B
    assert property (@(posedge clk) disable iff (!arst_n)
        w_done && wrt_w_last |=> wrt_b_ready && !wrt_w_valid && (beat == 0));

endmodule

`default_nettype wire

// ==== hdl/write_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module write_arbiter (
    input  wire l2_wr_pkg::wr_state_e        state,
    // l2 side
    input  wire                              l2_req,
    input  wire                              l2_uncached,
    input  wire  [31:0]                      l2_addr,
    input  wire  [l2_wr_pkg::LINE_BITS-1:0]  l2_line,
    input  wire  [2:0]                       l2_size,
    output logic                             l2_addr_ok,
    // write buffer side
    output logic                             wrt_req,
    output logic [31:0]                      wrt_addr,
    output logic [l2_wr_pkg::LINE_BITS-1:0]  wrt_line,
    input  wire                              wrt_addr_ok,
    input  wire                              wrt_aw_valid,
    input  wire  [31:0]                      wrt_aw_addr,
    output logic                             wrt_aw_ready,
    input  wire                              wrt_w_valid,
    input  wire  [31:0]                      wrt_w_data,
    input  wire                              wrt_w_last,
    output logic                             wrt_w_ready,
    input  wire                              wrt_b_ready,
    output logic                             wrt_b_valid,
    // axi write port
    output logic                             aw_valid,
    input  wire                              aw_ready,
    output logic [31:0]                      aw_addr,
    output logic [7:0]                       aw_len,
    output logic [2:0]                       aw_size,
    output logic                             w_valid,
    input  wire                              w_ready,
    output logic [31:0]                      w_data,
    output logic [3:0]                       w_strb,
    output logic                             w_last,
    input  wire                              b_valid,
    output logic                             b_ready
);

    import l2_wr_pkg::*;

    logic [3:0] dma_strb;
    logic       cached_req;

    assign cached_req = l2_req && !l2_uncached;

    // byte lanes of a direct store
    always_comb begin
        case (l2_size)
            SIZE_BYTE: dma_strb = 4'b0001 << l2_addr[1:0];
            SIZE_HALF: dma_strb = l2_addr[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: dma_strb = 4'b1111;
            default:   dma_strb = 4'b0000;
        endcase
    end

    always_comb begin
        l2_addr_ok   = 1'b0;
        wrt_req      = 1'b0;
        wrt_addr     = '0;
        wrt_line     = '0;
        wrt_aw_ready = 1'b0;
        wrt_w_ready  = 1'b0;
        wrt_b_valid  = 1'b0;
        aw_valid     = 1'b0;
        aw_addr      = '0;
        aw_len       = '0;
        aw_size      = '0;
        w_valid      = 1'b0;
        w_data       = '0;
        w_strb       = '0;
        w_last       = 1'b0;
        b_ready      = 1'b0;
        case (state)
            IDLE, WRT_W: begin
                // cached lines enter the buffer, port belongs to the buffer
                if (cached_req) begin
                    wrt_req  = 1'b1;
                    wrt_addr = l2_addr;
                    wrt_line = l2_line;
                end
                l2_addr_ok = cached_req && wrt_addr_ok;

                aw_valid = wrt_aw_valid;
                aw_addr  = wrt_aw_addr;
                aw_len   = 8'(LINE_WORDS - 1);
                aw_size  = SIZE_WORD;
                w_valid  = wrt_w_valid;
                w_data   = wrt_w_data;
                w_strb   = 4'hf;
                w_last   = wrt_w_last;
                b_ready  = wrt_b_ready;

                wrt_aw_ready = aw_ready;
                wrt_w_ready  = w_ready;
                wrt_b_valid  = b_valid;
            end
            DMA_AW, DMA_W, DMA_R: begin
                // single beat store, payload held through all three phases
                aw_addr = l2_addr;
                aw_size = l2_size;
                w_data  = l2_line[31:0];
                w_strb  = dma_strb;

                aw_valid   = (state == DMA_AW);
                w_valid    = (state == DMA_W);
                w_last     = (state == DMA_W);
                b_ready    = (state == DMA_R);
                l2_addr_ok = (state == DMA_R) && b_valid;
            end
            default: begin
                l2_addr_ok = 1'b0;
            end
        endcase
    end

    // odd half-word stores never come from the l2 cache
    assert property (@(posedge aw_valid)
        l2_req && l2_uncached |-> !((l2_size == SIZE_HALF) && l2_addr[0]));

endmodule

`default_nettype wire

// ==== hdl/l2_write_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_write_path (
    input  wire                              clk,
    input  wire                              arst_n,
    // l2 cache request
    input  wire                              l2_req,
    input  wire  [31:0]                      l2_addr,
    input  wire  [l2_wr_pkg::LINE_BITS-1:0]  l2_line,
    input  wire  [2:0]                       l2_size,
    input  wire                              l2_uncached,
    output wire                              l2_addr_ok,
    // axi write port
    output wire                              aw_valid,
    input  wire                              aw_ready,
    output wire  [31:0]                      aw_addr,
    output wire  [7:0]                       aw_len,
    output wire  [2:0]                       aw_size,
    output wire                              w_valid,
    input  wire                              w_ready,
    output wire  [31:0]                      w_data,
    output wire  [3:0]                       w_strb,
    output wire                              w_last,
    input  wire                              b_valid,
    output wire                              b_ready
);

    import l2_wr_pkg::*;

    wr_state_e            state;
    logic                 wrt_req;
    logic [31:0]          wrt_addr;
    logic [LINE_BITS-1:0] wrt_line;
    logic                 wrt_addr_ok;
    logic                 wrt_aw_valid;
    logic [31:0]          wrt_aw_addr;
    logic                 wrt_aw_ready;
    logic                 wrt_w_valid;
    logic [31:0]          wrt_w_data;
    logic                 wrt_w_last;
    logic                 wrt_w_ready;
    logic                 wrt_b_ready;
    logic                 wrt_b_valid;
    logic                 wrt_empty;

    l2_wr_ctrl ctrl0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .l2_req      (l2_req),
        .l2_uncached (l2_uncached),
        .wrt_empty   (wrt_empty),
        .aw_ready    (aw_ready),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .state       (state)
    );

    write_buffer wrt0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .wrt_req      (wrt_req),
        .wrt_addr     (wrt_addr),
        .wrt_line     (wrt_line),
        .wrt_addr_ok  (wrt_addr_ok),
        .wrt_aw_valid (wrt_aw_valid),
        .wrt_aw_addr  (wrt_aw_addr),
        .aw_ready     (wrt_aw_ready),
        .wrt_w_valid  (wrt_w_valid),
        .wrt_w_data   (wrt_w_data),
        .wrt_w_last   (wrt_w_last),
        .w_ready      (wrt_w_ready),
        .wrt_b_ready  (wrt_b_ready),
        .b_valid      (wrt_b_valid),
        .wrt_empty    (wrt_empty)
    );

    write_arbiter arb0 (
        .state        (state),
        .l2_req       (l2_req),
        .l2_uncached  (l2_uncached),
        .l2_addr      (l2_addr),
        .l2_line      (l2_line),
        .l2_size      (l2_size),
        .l2_addr_ok   (l2_addr_ok),
        .wrt_req      (wrt_req),
        .wrt_addr     (wrt_addr),
        .wrt_line     (wrt_line),
        .wrt_addr_ok  (wrt_addr_ok),
        .wrt_aw_valid (wrt_aw_valid),
        .wrt_aw_addr  (wrt_aw_addr),
        .wrt_aw_ready (wrt_aw_ready),
        .wrt_w_valid  (wrt_w_valid),
        .wrt_w_data   (wrt_w_data),
        .wrt_w_last   (wrt_w_last),
        .wrt_w_ready  (wrt_w_ready),
        .wrt_b_ready  (wrt_b_ready),
        .wrt_b_valid  (wrt_b_valid),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len),
        .aw_size      (aw_size),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .w_data       (w_data),
        .w_strb       (w_strb),
        .w_last       (w_last),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

endmodule

`default_nettype wire

// ==== dv/tb_l2_write_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_l2_write_path;

    import l2_wr_pkg::*;

    localparam int NUM_ROWS = 11;
    localparam int TIMEOUT  = 200;
    localparam int T_RESET  = 0;
    localparam int T_BURST  = 1;
    localparam int T_UNC    = 2;
    localparam int T_ORDER  = 3;
    localparam int T_BP     = 4;

    logic                 clk;
    logic                 arst_n;
    logic                 l2_req;
    logic [31:0]          l2_addr;
    logic [LINE_BITS-1:0] l2_line;
    logic [2:0]           l2_size;
    logic                 l2_uncached;
    wire                  l2_addr_ok;
    wire                  aw_valid;
    logic                 aw_ready;
    wire  [31:0]          aw_addr;
    wire  [7:0]           aw_len;
    wire  [2:0]           aw_size;
    wire                  w_valid;
    logic                 w_ready;
    wire  [31:0]          w_data;
    wire  [3:0]           w_strb;
    wire                  w_last;
    logic                 b_valid;
    wire                  b_ready;

    // stimulus table
    logic [31:0]          row_addr [NUM_ROWS];
    logic                 row_unc  [NUM_ROWS];
    logic [2:0]           row_size [NUM_ROWS];
    logic [3:0]           row_strb [NUM_ROWS];
    logic [LINE_BITS-1:0] row_line [NUM_ROWS];
    logic                 row_slow [NUM_ROWS];

    // slave log and memories, 256 bytes above 0x8000_0000
    logic [31:0] log_addr [$];
    logic [7:0]  log_len [$];
    logic [2:0]  log_size [$];
    logic [31:0] beat_data [$];
    logic [3:0]  beat_strb [$];
    logic        beat_last [$];
    logic [7:0]  mem [256];
    logic [7:0]  exp_mem [256];

    logic [31:0] lcg_state = 32'd60;
    logic        slow;
    int          errs [5];
    int          tests_passed;
    int          tests_failed;

    l2_write_path dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr),
        .l2_line     (l2_line),
        .l2_size     (l2_size),
        .l2_uncached (l2_uncached),
        .l2_addr_ok  (l2_addr_ok),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .aw_addr     (aw_addr),
        .aw_len      (aw_len),
        .aw_size     (aw_size),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w_data      (w_data),
        .w_strb      (w_strb),
        .w_last      (w_last),
        .b_valid     (b_valid),
        .b_ready     (b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:16];
    endfunction

    function automatic int pick_delay();
        if (slow) begin
            return 3;
        end
        return int'(next_random() % 4);
    endfunction

    task automatic set_row(input int n, input logic [31:0] addr, input logic unc,
                           input logic [2:0] size, input logic [3:0] strb,
                           input logic [LINE_BITS-1:0] line, input logic slw);
        row_addr[n] = addr;
        row_unc[n]  = unc;
        row_size[n] = size;
        row_strb[n] = strb;
        row_line[n] = line;
        row_slow[n] = slw;
    endtask

    // address, uncached, size, expected strobe, line, slow slave
    task automatic load_table();
        set_row(0, 32'h8000_0004, 0, SIZE_WORD, 4'hf, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 0);
        set_row(1, 32'h8000_0010, 0, SIZE_WORD, 4'hf, 128'h1f1e1d1c_1b1a1918_17161514_13121110, 0);
        set_row(2, 32'h8000_0041, 1, SIZE_BYTE, 4'h2, 128'h0000_a500, 0);
        set_row(3, 32'h8000_0046, 1, SIZE_HALF, 4'hc, 128'hbeef_0000, 0);
        set_row(4, 32'h8000_0048, 1, SIZE_WORD, 4'hf, 128'hcafe_f00d, 0);
        set_row(5, 32'h8000_0020, 0, SIZE_WORD, 4'hf, 128'h2f2e2d2c_2b2a2928_27262524_23222120, 0);
        // overwrites one byte of the line before it
        set_row(6, 32'h8000_0023, 1, SIZE_BYTE, 4'h8, 128'h5a00_0000, 0);
        // back-to-back lines under the slowest slave
        set_row(7, 32'h8000_0080, 0, SIZE_WORD, 4'hf, 128'h8f8e8d8c_8b8a8988_87868584_83828180, 1);
        set_row(8, 32'h8000_0090, 0, SIZE_WORD, 4'hf, 128'h9f9e9d9c_9b9a9998_97969594_93929190, 1);
        set_row(9, 32'h8000_00a0, 0, SIZE_WORD, 4'hf, 128'hafaeadac_abaaa9a8_a7a6a5a4_a3a2a1a0, 1);
        set_row(10, 32'h8000_0082, 1, SIZE_HALF, 4'hc, 128'h7777_0000, 1);
    endtask

    task automatic build_expected();
        logic [31:0] a;
        logic [3:0]  m;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = 8'h00;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (row_unc[i]) begin
                a = row_addr[i] & ~32'h3;
                m = row_strb[i];
                for (int b = 0; b < 4; b++) begin
                    if (m[b]) begin
                        exp_mem[(a + b) & 255] = row_line[i][b*8 +: 8];
                    end
                end
            end else begin
                a = row_addr[i] & ~32'(LINE_WORDS * 4 - 1);
                for (int b = 0; b < LINE_WORDS * 4; b++) begin
                    exp_mem[(a + b) & 255] = row_line[i][b*8 +: 8];
                end
            end
        end
    endtask

    task automatic report_error(input int t, input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errs[t]++;
    endtask

    task automatic finish_test(input int t, input string name);
        if (errs[t] == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, errs[t]);
            tests_failed++;
        end
    endtask

    task automatic abort_run(input string msg);
        $display("timeout at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic store_beat(input logic [31:0] addr, input int beat,
                              input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] a;
        a = (addr & ~32'h3) + 32'(4 * beat);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                mem[(a + b) & 255] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic check_idle_outputs();
        if (aw_valid || w_valid || b_ready || l2_addr_ok) begin
            report_error(T_RESET, $sformatf("handshake output high before any request: %b%b%b%b",
                                            aw_valid, w_valid, b_ready, l2_addr_ok));
        end
    endtask

    // drives one row and holds it until addrOK
    task automatic apply_row(input int n);
        int waited;
        slow        = row_slow[n];
        l2_req      = 1'b1;
        l2_addr     = row_addr[n];
        l2_uncached = row_unc[n];
        l2_size     = row_size[n];
        l2_line     = row_line[n];
        waited      = 0;
        #2;
        while (!l2_addr_ok && waited < TIMEOUT) begin
            @(negedge clk);
            #2;
            waited++;
        end
        if (!l2_addr_ok) begin
            abort_run($sformatf("no addrOK for row %0d", n));
        end else begin
            @(posedge clk);
            @(negedge clk);
        end
    endtask

    task automatic check_writes();
        int          bi;
        int          t;
        int          nbeats;
        int          total;
        int          seen;
        logic [31:0] ea;
        logic [31:0] ed;
        logic [3:0]  es;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += row_unc[i] ? 1 : LINE_WORDS;
        end
        if (beat_data.size() != total) begin
            report_error(T_BP, $sformatf("%0d data beats seen, expected %0d",
                                         beat_data.size(), total));
        end
        bi = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            t      = row_unc[i] ? T_UNC : T_BURST;
            nbeats = row_unc[i] ? 1 : LINE_WORDS;
            ea     = row_unc[i] ? row_addr[i] : row_addr[i] & ~32'(LINE_WORDS * 4 - 1);
            if (log_addr[i] != ea) begin
                report_error(T_ORDER, $sformatf("write %0d to %h, expected %h", i, log_addr[i], ea));
            end
            if (log_len[i] != nbeats - 1) begin
                report_error(t, $sformatf("write %0d aw_len %0d", i, log_len[i]));
            end
            if (log_size[i] != (row_unc[i] ? row_size[i] : SIZE_WORD)) begin
                report_error(t, $sformatf("write %0d aw_size %0d", i, log_size[i]));
            end
            for (int b = 0; b < nbeats; b++) begin
                ed = row_line[i][b*32 +: 32];
                es = row_strb[i];
                if (bi < beat_data.size()) begin
                    if (beat_data[bi] !== ed || beat_strb[bi] !== es) begin
                        report_error(t, $sformatf("write %0d beat %0d data %h strb %b, expected %h %b",
                                                  i, b, beat_data[bi], beat_strb[bi], ed, es));
                    end
                    if (beat_last[bi] !== (b == nbeats - 1)) begin
                        report_error(t, $sformatf("write %0d beat %0d w_last %b", i, b, beat_last[bi]));
                    end
                end
                bi++;
            end
            if (row_slow[i] && !row_unc[i]) begin
                seen = 0;
                foreach (log_addr[k]) begin
                    seen += (log_addr[k] == ea) ? 1 : 0;
                end
                if (seen != 1) begin
                    report_error(T_BP, $sformatf("line of row %0d written %0d times", i, seen));
                end
            end
        end
        for (int i = 0; i < 256; i++) begin
            if (mem[i] !== exp_mem[i]) begin
                report_error(T_UNC, $sformatf("memory byte %h is %h, expected %h",
                                              32'h8000_0000 + i, mem[i], exp_mem[i]));
            end
        end
    endtask

    // axi slave, one write at a time
    initial begin : responder
        logic [31:0] burst_addr;
        logic [7:0]  burst_len;
        int          waited;
        forever begin
            @(negedge clk);
            if (arst_n && aw_valid) begin
                wait_cycles(pick_delay());
                burst_addr = aw_addr;
                burst_len  = aw_len;
                log_size.push_back(aw_size);
                aw_ready = 1'b1;
                @(negedge clk);
                aw_ready = 1'b0;
                for (int i = 0; i <= burst_len; i++) begin
                    waited = 0;
                    while (!w_valid && waited < TIMEOUT) begin
                        @(negedge clk);
                        waited++;
                    end
                    if (!w_valid) begin
                        abort_run("write data never arrived after an address handshake");
                    end else begin
                        wait_cycles(pick_delay());
                        beat_data.push_back(w_data);
                        beat_strb.push_back(w_strb);
                        beat_last.push_back(w_last);
                        store_beat(burst_addr, i, w_data, w_strb);
                        w_ready = 1'b1;
                        @(negedge clk);
                        w_ready = 1'b0;
                    end
                end
                waited = 0;
                while (!b_ready && waited < TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                if (!b_ready) begin
                    abort_run("b_ready never rose after the last data beat");
                end else begin
                    wait_cycles(pick_delay());
                    b_valid = 1'b1;
                    log_addr.push_back(burst_addr);
                    log_len.push_back(burst_len);
                    @(negedge clk);
                    b_valid = 1'b0;
                end
            end
        end
    end

    initial begin : main
        int waited;
        arst_n      = 1'b0;
        l2_req      = 1'b0;
        l2_addr     = '0;
        l2_line     = '0;
        l2_size     = SIZE_WORD;
        l2_uncached = 1'b0;
        aw_ready    = 1'b0;
        w_ready     = 1'b0;
        b_valid     = 1'b0;
        slow        = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'h00;
        end
        load_table();
        build_expected();

        repeat (16) begin
            @(negedge clk);
            check_idle_outputs();
        end
        arst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs();
        end
        finish_test(T_RESET, "reset");

        for (int n = 0; n < NUM_ROWS; n++) begin
            apply_row(n);
        end
        l2_req = 1'b0;

        waited = 0;
        while (log_addr.size() < NUM_ROWS && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (log_addr.size() < NUM_ROWS) begin
            abort_run($sformatf("only %0d of %0d writes completed", log_addr.size(), NUM_ROWS));
        end else begin
            wait_cycles(4);
            check_writes();
            finish_test(T_BURST, "cached line bursts");
            finish_test(T_UNC, "uncached stores");
            finish_test(T_ORDER, "write ordering");
            finish_test(T_BP, "back-pressure");
            $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/l2_wr_pkg.sv
hdl/l2_wr_ctrl.sv
hdl/write_buffer.sv
hdl/write_arbiter.sv
hdl/l2_write_path.sv
dv/tb_l2_write_path.sv

// ==== Bender.yml ====
package:
  name: l2_write_path

sources:
  - hdl/l2_wr_pkg.sv
  - hdl/l2_wr_ctrl.sv
  - hdl/write_buffer.sv
  - hdl/write_arbiter.sv
  - hdl/l2_write_path.sv
  - target: test
    files:
      - dv/tb_l2_write_path.sv
